// ==== l2_consts.svh ====
`ifndef L2_CONSTS_SVH
`define L2_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Memory geometry
//////////////////////////////////////////////////////////////////////

`define L2_WORD_WIDTH 32
`define L2_BUS_WORDS  4
`define L2_BURST      4
`define L2_ADDR_WIDTH 10
`define L2_DEPTH      (1 << `L2_ADDR_WIDTH)
`define L2_BEAT_WIDTH (`L2_BUS_WORDS * `L2_WORD_WIDTH)

// Word address split into block, beat and lane
`define L2_LANE_BITS  $clog2(`L2_BUS_WORDS)
`define L2_BEAT_BITS  $clog2(`L2_BURST)
`define L2_BLOCK_BITS (`L2_ADDR_WIDTH - `L2_BEAT_BITS - `L2_LANE_BITS)

// Latencies in counted clock edges
`define L2_DELAY_RD 7
`define L2_DELAY_WR 4

`endif

// ==== l2_pkg.sv ====
`include "l2_consts.svh"

package l2_pkg;

    // One bus beat, word 0 in the low bits
    typedef logic [`L2_BEAT_WIDTH-1:0] l2_beat_t;

    typedef struct packed {
        logic [`L2_BLOCK_BITS-1:0] block;
        logic [`L2_BEAT_BITS-1:0]  beat;
        logic [`L2_LANE_BITS-1:0]  lane;
    } l2_addr_fields_t;

    // Same word address, seen flat or split into fields
    typedef union packed {
        logic [`L2_ADDR_WIDTH-1:0] index;
        l2_addr_fields_t           fields;
    } l2_word_addr_u;

endpackage

// ==== l2_req_decode.sv ====
`include "l2_consts.svh"

module l2_req_decode (
    input  logic                       CLK,
    input  logic                       rst_n,
    input  l2_pkg::l2_word_addr_u      rd_addr,
    input  logic                       rd_addr_valid,
    input  logic                       rd_data_ready,
    output logic                       rd_addr_ready,
    output logic                       req_mature,
    output logic [`L2_BLOCK_BITS-1:0]  req_block
);

    localparam int unsigned line_depth = `L2_DELAY_RD - 2;

    logic                      ready_flag;
    logic [`L2_BURST-1:0]      gap_state;
    logic                      req_accept;
    logic [line_depth-1:0]     pend_valid;
    logic [`L2_BLOCK_BITS-1:0] pend_block [line_depth];

    assign rd_addr_ready = ready_flag & rd_data_ready;
    assign req_accept    = rd_addr_valid & rd_addr_ready;

    //////////////////////////////////////////////////////////////////////
    // Acceptance and burst gap
    //////////////////////////////////////////////////////////////////////

    // One request per burst slot, ready comes back one edge early
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            ready_flag <= 1'b1;
            gap_state  <= '0;
        end else if (rd_data_ready) begin
            if (req_accept) begin
                ready_flag <= 1'b0;
                gap_state  <= {{(`L2_BURST-1){1'b0}}, 1'b1};
            end else if (|gap_state) begin
                gap_state <= gap_state << 1;
            end

            if (gap_state[`L2_BURST-2]) begin
                ready_flag <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Request delay line
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            pend_valid <= '0;
        end else if (rd_data_ready) begin
            pend_valid <= {pend_valid[line_depth-2:0], req_accept};
        end
    end

    // Block indices ride along with the valid bits
    always_ff @(posedge CLK) begin
        if (rd_data_ready) begin
            pend_block[0] <= rd_addr.fields.block;
            for (int s = 1; s < line_depth; s++) begin
                pend_block[s] <= pend_block[s-1];
            end
        end
    end

    assign req_mature = pend_valid[line_depth-1];
    assign req_block  = pend_block[line_depth-1];

endmodule

// ==== l2_wr_burst.sv ====
`include "l2_consts.svh"

module l2_wr_burst (
    input  logic                       CLK,
    input  logic                       rst_n,
    input  l2_pkg::l2_word_addr_u      wr_addr,
    input  l2_pkg::l2_beat_t           wr_data,
    input  logic                       wr_valid,
    output logic                       wr_ready,
    output logic                       wr_complete,
    output logic                       mem_we,
    output logic [`L2_BLOCK_BITS-1:0]  mem_wr_block,
    output logic [`L2_BEAT_BITS-1:0]   mem_wr_beat,
    output l2_pkg::l2_beat_t           mem_wr_data
);

    localparam int unsigned state_width = `L2_BURST + `L2_DELAY_WR;

    logic [state_width-1:0]    wr_state;
    logic [`L2_BEAT_BITS-1:0]  beat_cnt;
    logic [`L2_BLOCK_BITS-1:0] block_q;
    logic                      beat_accept;

    // Low bits of the one-hot state take beats, top bit is completion
    assign wr_ready    = |wr_state[`L2_BURST-1:0];
    assign wr_complete = wr_state[state_width-1];
    assign beat_accept = wr_valid & wr_ready;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            wr_state <= {{(state_width-1){1'b0}}, 1'b1};
            beat_cnt <= '0;
        end else if (wr_ready) begin
            if (wr_valid) begin
                wr_state <= wr_state << 1;
                beat_cnt <= beat_cnt + 1'b1;
            end
        end else begin
            // Completion delay runs on its own
            if (wr_complete) begin
                wr_state <= {{(state_width-1){1'b0}}, 1'b1};
            end else begin
                wr_state <= wr_state << 1;
            end
            beat_cnt <= '0;
        end
    end

    // Block taken from the first beat only
    always_ff @(posedge CLK) begin
        if (beat_accept && wr_state[0]) begin
            block_q <= wr_addr.fields.block;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Array write port
    //////////////////////////////////////////////////////////////////////

    assign mem_we       = beat_accept;
    assign mem_wr_block = wr_state[0] ? wr_addr.fields.block : block_q;
    assign mem_wr_beat  = beat_cnt;
    assign mem_wr_data  = wr_data;

endmodule

// ==== l2_mem_array.sv ====
`include "l2_consts.svh"

module l2_mem_array (
    input  logic                       CLK,
    input  logic                       mem_we,
    input  logic [`L2_BLOCK_BITS-1:0]  mem_wr_block,
    input  logic [`L2_BEAT_BITS-1:0]   mem_wr_beat,
    input  l2_pkg::l2_beat_t           mem_wr_data,
    input  logic [`L2_BLOCK_BITS-1:0]  rd_block,
    input  logic [`L2_BEAT_BITS-1:0]   rd_beat,
    output l2_pkg::l2_beat_t           rd_beat_data
);

    logic [`L2_WORD_WIDTH-1:0] mem [`L2_DEPTH];

    l2_pkg::l2_word_addr_u wr_word_addr [`L2_BUS_WORDS];
    l2_pkg::l2_word_addr_u rd_word_addr [`L2_BUS_WORDS];

    //////////////////////////////////////////////////////////////////////
    // Per-lane word addresses
    //////////////////////////////////////////////////////////////////////

    // Fields in, flat index out
    always_comb begin
        for (int i = 0; i < `L2_BUS_WORDS; i++) begin
            wr_word_addr[i].fields.block = mem_wr_block;
            wr_word_addr[i].fields.beat  = mem_wr_beat;
            wr_word_addr[i].fields.lane  = i[`L2_LANE_BITS-1:0];
            rd_word_addr[i].fields.block = rd_block;
            rd_word_addr[i].fields.beat  = rd_beat;
            rd_word_addr[i].fields.lane  = i[`L2_LANE_BITS-1:0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (mem_we) begin
            for (int i = 0; i < `L2_BUS_WORDS; i++) begin
                mem[wr_word_addr[i].index] <= mem_wr_data[i*`L2_WORD_WIDTH +: `L2_WORD_WIDTH];
            end
        end
    end

    // Lane order, word 0 lowest
    always_comb begin
        for (int i = 0; i < `L2_BUS_WORDS; i++) begin
            rd_beat_data[i*`L2_WORD_WIDTH +: `L2_WORD_WIDTH] = mem[rd_word_addr[i].index];
        end
    end

endmodule

// ==== l2_beat_result.sv ====
`include "l2_consts.svh"

module l2_beat_result (
    input  logic                       CLK,
    input  logic                       rst_n,
    input  logic                       rd_data_ready,
    input  logic                       req_mature,
    input  logic [`L2_BLOCK_BITS-1:0]  req_block,
    input  l2_pkg::l2_beat_t           rd_beat_data,
    output logic [`L2_BLOCK_BITS-1:0]  rd_block,
    output logic [`L2_BEAT_BITS-1:0]   rd_beat,
    output l2_pkg::l2_beat_t           rd_data,
    output logic                       rd_data_valid
);

    logic [`L2_BURST-1:0] beat_state;

    //////////////////////////////////////////////////////////////////////
    // Beat sequencing
    //////////////////////////////////////////////////////////////////////

    // A new request takes over as the previous one leaves its last beat
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            beat_state    <= '0;
            rd_data_valid <= 1'b0;
        end else if (rd_data_ready) begin
            if (req_mature) begin
                beat_state <= {{(`L2_BURST-1){1'b0}}, 1'b1};
            end else if (|beat_state) begin
                beat_state <= beat_state << 1;
            end
            rd_data_valid <= |beat_state;
        end
    end

    // One-hot state to beat index
    always_comb begin
        rd_beat = '0;
        for (int k = 0; k < `L2_BURST; k++) begin
            if (beat_state[k]) begin
                rd_beat = k[`L2_BEAT_BITS-1:0];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Block and data registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (rd_data_ready) begin
            if (req_mature) begin
                rd_block <= req_block;
            end
            if (|beat_state) begin
                rd_data <= rd_beat_data;
            end
        end
    end

endmodule

// ==== l2_mem_model.sv ====
`include "l2_consts.svh"

module l2_mem_model (
    input  logic                   CLK,
    input  logic                   rst_n,
    // Read side
    input  l2_pkg::l2_word_addr_u  rd_addr,
    input  logic                   rd_addr_valid,
    output logic                   rd_addr_ready,
    input  logic                   rd_data_ready,
    output l2_pkg::l2_beat_t       rd_data,
    output logic                   rd_data_valid,
    // Write side
    input  l2_pkg::l2_word_addr_u  wr_addr,
    input  l2_pkg::l2_beat_t       wr_data,
    input  logic                   wr_valid,
    output logic                   wr_ready,
    output logic                   wr_complete
);

    logic                      req_mature;
    logic [`L2_BLOCK_BITS-1:0] req_block;
    logic [`L2_BLOCK_BITS-1:0] rd_block;
    logic [`L2_BEAT_BITS-1:0]  rd_beat;
    l2_pkg::l2_beat_t          rd_beat_data;

    logic                      mem_we;
    logic [`L2_BLOCK_BITS-1:0] mem_wr_block;
    logic [`L2_BEAT_BITS-1:0]  mem_wr_beat;
    l2_pkg::l2_beat_t          mem_wr_data;

    //////////////////////////////////////////////////////////////////////
    // Read path
    //////////////////////////////////////////////////////////////////////

    l2_req_decode u_l2_req_decode (
        .CLK           (CLK),
        .rst_n         (rst_n),
        .rd_addr       (rd_addr),
        .rd_addr_valid (rd_addr_valid),
        .rd_data_ready (rd_data_ready),
        .rd_addr_ready (rd_addr_ready),
        .req_mature    (req_mature),
        .req_block     (req_block)
    );

    l2_beat_result u_l2_beat_result (
        .CLK           (CLK),
        .rst_n         (rst_n),
        .rd_data_ready (rd_data_ready),
        .req_mature    (req_mature),
        .req_block     (req_block),
        .rd_beat_data  (rd_beat_data),
        .rd_block      (rd_block),
        .rd_beat       (rd_beat),
        .rd_data       (rd_data),
        .rd_data_valid (rd_data_valid)
    );

    //////////////////////////////////////////////////////////////////////
    // Write path and storage
    //////////////////////////////////////////////////////////////////////

    l2_wr_burst u_l2_wr_burst (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .wr_valid     (wr_valid),
        .wr_ready     (wr_ready),
        .wr_complete  (wr_complete),
        .mem_we       (mem_we),
        .mem_wr_block (mem_wr_block),
        .mem_wr_beat  (mem_wr_beat),
        .mem_wr_data  (mem_wr_data)
    );

    l2_mem_array u_l2_mem_array (
        .CLK          (CLK),
        .mem_we       (mem_we),
        .mem_wr_block (mem_wr_block),
        .mem_wr_beat  (mem_wr_beat),
        .mem_wr_data  (mem_wr_data),
        .rd_block     (rd_block),
        .rd_beat      (rd_beat),
        .rd_beat_data (rd_beat_data)
    );

endmodule

// ==== tb_l2_mem_model.sv ====
`include "l2_consts.svh"

module tb_l2_mem_model;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned max_wait = 200;

    logic                  CLK;
    logic                  rst_n;
    l2_pkg::l2_word_addr_u rd_addr;
    logic                  rd_addr_valid;
    logic                  rd_addr_ready;
    logic                  rd_data_ready;
    l2_pkg::l2_beat_t      rd_data;
    logic                  rd_data_valid;
    l2_pkg::l2_word_addr_u wr_addr;
    l2_pkg::l2_beat_t      wr_data;
    logic                  wr_valid;
    logic                  wr_ready;
    logic                  wr_complete;

    // Reference model and expected read beats
    logic [`L2_WORD_WIDTH-1:0] model_mem [int];
    l2_pkg::l2_beat_t          exp_data [$];
    int                        exp_due [$];
    int                        blocks [8];
    logic                      used [int];

    int               cyc = 0;
    int               rd_cnt = 0;
    int               last_acc = -100;
    int               last_wr = -100;
    int               wr_idx = 0;
    int               wr_blk = 0;
    logic             mon_on = 1'b0;
    logic             bp_on = 1'b0;
    logic             prev_ready = 1'b1;
    logic             prev_valid = 1'b0;
    l2_pkg::l2_beat_t prev_data;

    l2_mem_model u_l2_mem_model (.*);

    always #10 CLK = ~CLK;

    task automatic check_value(string name, logic [`L2_BEAT_WIDTH-1:0] exp,
                               logic [`L2_BEAT_WIDTH-1:0] act);
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    task automatic fail_run(string msg);
        $display("%s at %0t", msg, $time);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    ////////////////////////////////////////////////////////////////////
    // Monitor sampled at the rising edge before any update
    ////////////////////////////////////////////////////////////////////

    always @(posedge CLK) begin
        l2_pkg::l2_beat_t beat;
        int               base;
        if (rst_n && mon_on) begin
            check_value("wr_complete", cyc == last_wr + `L2_DELAY_WR, wr_complete);
            check_value("wr_ready", !(cyc > last_wr && cyc <= last_wr + `L2_DELAY_WR),
                        wr_ready);
            if (wr_valid && wr_ready) begin
                if (wr_idx == 0) begin
                    wr_blk = wr_addr.fields.block;
                end
                base = wr_blk * `L2_BURST * `L2_BUS_WORDS + wr_idx * `L2_BUS_WORDS;
                for (int i = 0; i < `L2_BUS_WORDS; i++) begin
                    model_mem[base + i] = wr_data[i*`L2_WORD_WIDTH +: `L2_WORD_WIDTH];
                end
                if (wr_idx == `L2_BURST - 1) begin
                    last_wr = cyc;
                    wr_idx  = 0;
                end else begin
                    wr_idx++;
                end
            end

            // Outputs frozen across a stalled edge
            if (!prev_ready) begin
                check_value("rd_data_valid", prev_valid, rd_data_valid);
                check_value("rd_data", prev_data, rd_data);
            end

            if (rd_data_valid) begin
                if (exp_due.size() == 0 || exp_due[0] != rd_cnt) begin
                    check_value("rd_data_valid", 1'b0, rd_data_valid);
                end
                if (rd_data_ready) begin
                    check_value("rd_data", exp_data.pop_front(), rd_data);
                    void'(exp_due.pop_front());
                end
            end else if (exp_due.size() != 0 && exp_due[0] <= rd_cnt) begin
                check_value("rd_data_valid", 1'b1, rd_data_valid);
            end

            // Ready drops on acceptance and is back a burst slot later
            check_value("rd_addr_ready",
                        rd_data_ready && (rd_cnt >= last_acc + `L2_BURST), rd_addr_ready);

            if (rd_addr_valid && rd_addr_ready) begin
                last_acc = rd_cnt;
                base = rd_addr.fields.block * `L2_BURST * `L2_BUS_WORDS;
                for (int k = 0; k < `L2_BURST; k++) begin
                    for (int i = 0; i < `L2_BUS_WORDS; i++) begin
                        beat[i*`L2_WORD_WIDTH +: `L2_WORD_WIDTH] =
                            model_mem[base + k * `L2_BUS_WORDS + i];
                    end
                    exp_data.push_back(beat);
                    exp_due.push_back(rd_cnt + `L2_DELAY_RD + k);
                end
            end

            if (rd_data_ready) begin
                rd_cnt++;
            end
            prev_ready = rd_data_ready;
            prev_valid = rd_data_valid;
            prev_data  = rd_data;
            cyc++;
        end
    end

    // Random stall of the read consumer at 30 percent
    always @(posedge CLK) begin
        if (bp_on) begin
            rd_data_ready <= ($urandom % 100) >= 30;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Stimulus tasks entered right after a rising edge
    ////////////////////////////////////////////////////////////////////

    task automatic write_block(int blk);
        int n;
        for (int k = 0; k < `L2_BURST; k++) begin
            wr_valid <= 1'b1;
            if (k == 0) begin
                wr_addr.index <= {blk[`L2_BLOCK_BITS-1:0], 4'($urandom)};
            end else begin
                // Later beats carry unrelated addresses
                wr_addr <= l2_pkg::l2_word_addr_u'($urandom);
            end
            wr_data <= {$urandom, $urandom, $urandom, $urandom};
            n = 0;
            do begin
                @(posedge CLK);
                n++;
                if (n > max_wait) begin
                    fail_run("Timeout waiting for wr_ready");
                end
            end while (!wr_ready);
        end
        wr_valid <= 1'b0;
        n = 0;
        do begin
            @(posedge CLK);
            n++;
            if (n > max_wait) begin
                fail_run("Timeout waiting for wr_complete");
            end
        end while (!wr_complete);
        @(posedge CLK);
    endtask

    task automatic issue_read(int blk);
        int n;
        rd_addr_valid <= 1'b1;
        rd_addr.index <= {blk[`L2_BLOCK_BITS-1:0], 4'($urandom)};
        n = 0;
        do begin
            @(posedge CLK);
            n++;
            if (n > max_wait) begin
                fail_run("Timeout waiting for rd_addr_ready");
            end
        end while (!(rd_addr_ready && rd_data_ready));
    endtask

    task automatic wait_drain();
        int n;
        rd_addr_valid <= 1'b0;
        n = 0;
        do begin
            @(posedge CLK);
            n++;
            if (n > max_wait) begin
                fail_run("Timeout waiting for read beats to drain");
            end
        end while (exp_due.size() != 0);
        @(posedge CLK);
    endtask

    initial begin
        int b;
        void'($urandom(32'h27fd958e));
        CLK           = 1'b0;
        rst_n         = 1'b0;
        rd_addr       = '0;
        rd_addr_valid = 1'b0;
        rd_data_ready = 1'b1;
        wr_addr       = '0;
        wr_data       = '0;
        wr_valid      = 1'b0;
        repeat (16) @(posedge CLK);
        rst_n <= 1'b1;
        @(posedge CLK);
        check_value("rd_addr_ready", 1'b1, rd_addr_ready);
        check_value("wr_ready", 1'b1, wr_ready);
        check_value("rd_data_valid", 1'b0, rd_data_valid);
        check_value("wr_complete", 1'b0, wr_complete);
        mon_on = 1'b1;

        for (int j = 0; j < 8; j++) begin
            do b = $urandom % (1 << `L2_BLOCK_BITS); while (used.exists(b));
            used[b]   = 1'b1;
            blocks[j] = b;
            write_block(b);
        end

        // Single read and then back-to-back reads
        issue_read(blocks[0]);
        wait_drain();
        for (int j = 0; j < 8; j++) begin
            issue_read(blocks[j]);
        end
        wait_drain();

        bp_on = 1'b1;
        for (int j = 0; j < 200; j++) begin
            issue_read(blocks[$urandom % 8]);
        end
        wait_drain();
        bp_on = 1'b0;

        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+.
l2_pkg.sv
l2_req_decode.sv
l2_wr_burst.sv
l2_mem_array.sv
l2_beat_result.sv
l2_mem_model.sv
tb_l2_mem_model.sv

// ==== Bender.yml ====
package:
  name: l2_mem_model

sources:
  - include_dirs:
      - .
    files:
      - l2_pkg.sv
      - l2_req_decode.sv
      - l2_wr_burst.sv
      - l2_mem_array.sv
      - l2_beat_result.sv
      - l2_mem_model.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_l2_mem_model.sv
